// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    localparam int data_w = 8;  // Byte wide datapath
    localparam int pc_w   = 8;  // Up to 256 instruction words

    typedef logic [data_w-1:0] data_t;
    typedef logic [pc_w-1:0]   pc_t;

    // ALU operations, 4 bit field of the instruction word
    typedef enum logic [3:0] {
        pass_a, pass_b,
        add, adc, sub, sbc,
        and_op, or_op, xor_op, not_b,
        shl, shr,
        inc_a, dec_a
    } alu_op_t;

    // A bus sources, low two bits select the register file port L
    typedef enum logic [2:0] {
        adev_rega, adev_regb, adev_regc, adev_regd,
        adev_marlo, adev_marhi, adev_rx, adev_zero
    } adev_t;

    // B bus sources, low two bits select the register file port R
    typedef enum logic [2:0] {
        bdev_rega, bdev_regb, bdev_regc, bdev_regd,
        bdev_marlo, bdev_marhi, bdev_ram, bdev_immed
    } bdev_t;

    // Targets of the ALU result
    typedef enum logic [3:0] {
        tdev_rega, tdev_regb, tdev_regc, tdev_regd,
        tdev_marlo, tdev_marhi, tdev_ram, tdev_tx,
        tdev_pc, tdev_halt, tdev_none
    } tdev_t;

    typedef enum logic [2:0] {
        cond_always, cond_z, cond_nz, cond_c,
        cond_nc, cond_di, cond_do, cond_lt
    } cond_t;

    // One ROM word, 26 bits, MSB first
    typedef struct packed {
        cond_t   cond;
        logic    set_flags;  // Load status register when executed
        alu_op_t alu_op;
        tdev_t   targ;
        adev_t   adev;
        bdev_t   bdev;
        data_t   immed8;
    } instr_t;

    // Status register, same bit order as czonGLEN
    typedef struct packed {
        logic c;
        logic z;
        logic o;
        logic n;
        logic gt;
        logic lt;
        logic eq;
        logic ne;
    } flags_t;

    typedef enum logic [1:0] {st_run, st_stall, st_halted} seq_state_t;

    // Fill word for unloaded ROM locations
    localparam instr_t nop_instr = '{
        cond: cond_always, set_flags: 1'b0, alu_op: pass_a, targ: tdev_none,
        adev: adev_zero, bdev: bdev_immed, immed8: '0
    };

endpackage

// ==== verilog/program_rom.sv ====
module program_rom #(
    parameter int depth = 256
) (
    input  logic            system_clk,
    input  logic            prog_we,     // Load strobe from the testbench or a loader
    input  cpu_pkg::pc_t    prog_addr,
    input  cpu_pkg::instr_t prog_data,
    input  cpu_pkg::pc_t    pc,
    output cpu_pkg::instr_t instr
);

    localparam int aw = $clog2(depth);  // Low pc bits used when depth is below 256

    cpu_pkg::instr_t mem [depth];

    // Power up as a no-op program
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = cpu_pkg::nop_instr;
        end
    end

    always @(posedge system_clk) begin
        if (prog_we) begin
            mem[prog_addr[aw-1:0]] <= prog_data;
        end
    end

    assign instr = mem[pc[aw-1:0]];  // Fetch is combinational

endmodule

// ==== verilog/sequencer.sv ====
module sequencer (
    input  logic            system_clk,
    input  logic            rst,
    input  cpu_pkg::instr_t instr,
    input  cpu_pkg::data_t  result,     // ALU output, also the jump address
    input  cpu_pkg::flags_t alu_flags,
    input  logic            di,         // Receive holder has a byte
    input  logic            do_rdy,     // Transmit holder is empty
    output cpu_pkg::pc_t    pc,
    output cpu_pkg::flags_t flags,
    output logic            reg_we,
    output logic            mar_lo_we,
    output logic            mar_hi_we,
    output logic            ram_we,
    output logic            tx_load,
    output logic            rx_take,
    output logic            halted
);

    cpu_pkg::seq_state_t state;
    cpu_pkg::seq_state_t state_nxt;
    logic                cond_ok;    // Execute condition holds
    logic                stall_hit;  // Condition holds but a holder is not ready
    logic                exec;       // Commit this instruction at the next edge
    logic                pc_load;
    logic                halt_hit;

    // Condition against registered flags and port status
    always_comb begin
        case (instr.cond)
            cpu_pkg::cond_always: cond_ok = 1'b1;
            cpu_pkg::cond_z:      cond_ok = flags.z;
            cpu_pkg::cond_nz:     cond_ok = !flags.z;
            cpu_pkg::cond_c:      cond_ok = flags.c;
            cpu_pkg::cond_nc:     cond_ok = !flags.c;
            cpu_pkg::cond_di:     cond_ok = di;
            cpu_pkg::cond_do:     cond_ok = do_rdy;
            cpu_pkg::cond_lt:     cond_ok = flags.lt;
            default:              cond_ok = 1'b0;
        endcase
    end

    // A skipped instruction never waits on the byte port
    assign stall_hit = cond_ok
                       && ((instr.adev == cpu_pkg::adev_rx && !di)
                           || (instr.targ == cpu_pkg::tdev_tx && !do_rdy));

    assign exec = cond_ok && !stall_hit && (state != cpu_pkg::st_halted);

    // Target decode into write strobes
    always_comb begin
        reg_we    = 1'b0;
        mar_lo_we = 1'b0;
        mar_hi_we = 1'b0;
        ram_we    = 1'b0;
        tx_load   = 1'b0;
        pc_load   = 1'b0;
        halt_hit  = 1'b0;
        if (exec) begin
            case (instr.targ)
                cpu_pkg::tdev_rega,
                cpu_pkg::tdev_regb,
                cpu_pkg::tdev_regc,
                cpu_pkg::tdev_regd:  reg_we = 1'b1;  // Index taken from targ at the top
                cpu_pkg::tdev_marlo: mar_lo_we = 1'b1;
                cpu_pkg::tdev_marhi: mar_hi_we = 1'b1;
                cpu_pkg::tdev_ram:   ram_we = 1'b1;
                cpu_pkg::tdev_tx:    tx_load = 1'b1;
                cpu_pkg::tdev_pc:    pc_load = 1'b1;
                cpu_pkg::tdev_halt:  halt_hit = 1'b1;
                default:             ;               // tdev_none
            endcase
        end
    end

    assign rx_take = exec && (instr.adev == cpu_pkg::adev_rx);  // Pop on use

    always_comb begin
        case (state)
            cpu_pkg::st_run,
            cpu_pkg::st_stall: begin
                if (halt_hit) begin
                    state_nxt = cpu_pkg::st_halted;
                end else if (stall_hit) begin
                    state_nxt = cpu_pkg::st_stall;
                end else begin
                    state_nxt = cpu_pkg::st_run;
                end
            end
            cpu_pkg::st_halted: state_nxt = cpu_pkg::st_halted;  // Only rst leaves
            default:            state_nxt = cpu_pkg::st_run;
        endcase
    end

    always_ff @(posedge system_clk) begin
        if (rst) begin
            state <= cpu_pkg::st_run;
            pc    <= '0;
            flags <= '0;
        end else begin
            state <= state_nxt;
            if (pc_load) begin
                pc <= result;                      // Jump
            end else if (state != cpu_pkg::st_halted && !stall_hit) begin
                pc <= pc + cpu_pkg::pc_t'(1);      // Executed or skipped
            end
            // Skipped instructions leave the flags alone
            if (exec && instr.set_flags) begin
                flags <= alu_flags;
            end
        end
    end

    assign halted = (state == cpu_pkg::st_halted);

endmodule

// ==== verilog/alu.sv ====
module alu (
    input  cpu_pkg::data_t   a,
    input  cpu_pkg::data_t   b,
    input  cpu_pkg::alu_op_t op,
    input  logic             carry_in,  // Registered carry for adc and sbc
    output cpu_pkg::data_t   result,
    output cpu_pkg::flags_t  flags
);

    logic [8:0] wide;  // Bit 8 is carry out or borrow
    logic       ovf;   // Signed overflow

    always_comb begin
        ovf = 1'b0;
        case (op)
            cpu_pkg::pass_a: wide = {1'b0, a};
            cpu_pkg::pass_b: wide = {1'b0, b};
            cpu_pkg::add: begin
                wide = {1'b0, a} + {1'b0, b};
                ovf  = (a[7] == b[7]) && (wide[7] != a[7]);
            end
            cpu_pkg::adc: begin
                wide = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};
                ovf  = (a[7] == b[7]) && (wide[7] != a[7]);
            end
            cpu_pkg::sub: begin
                wide = {1'b0, a} - {1'b0, b};  // Borrow lands in bit 8
                ovf  = (a[7] != b[7]) && (wide[7] != a[7]);
            end
            cpu_pkg::sbc: begin
                wide = {1'b0, a} - {1'b0, b} - {8'd0, carry_in};
                ovf  = (a[7] != b[7]) && (wide[7] != a[7]);
            end
            cpu_pkg::and_op: wide = {1'b0, a & b};
            cpu_pkg::or_op:  wide = {1'b0, a | b};
            cpu_pkg::xor_op: wide = {1'b0, a ^ b};
            cpu_pkg::not_b:  wide = {1'b0, ~b};
            cpu_pkg::shl:    wide = {a, 1'b0};             // Top bit out to carry
            cpu_pkg::shr:    wide = {a[0], 1'b0, a[7:1]};  // Bottom bit out to carry
            cpu_pkg::inc_a: begin
                wide = {1'b0, a} + 9'd1;
                ovf  = !a[7] && wide[7];                  // 7f to 80
            end
            cpu_pkg::dec_a: begin
                wide = {1'b0, a} - 9'd1;
                ovf  = a[7] && !wide[7];                  // 80 to 7f
            end
            default: wide = '0;                           // Unused opcodes
        endcase
    end

    assign result = wide[7:0];

    always_comb begin
        flags.c  = wide[8];
        flags.z  = (wide[7:0] == '0);
        flags.o  = ovf;
        flags.n  = wide[7];
        // Unsigned compare of the operands, independent of op
        flags.gt = (a > b);
        flags.lt = (a < b);
        flags.eq = (a == b);
        flags.ne = (a != b);
    end

endmodule

// ==== verilog/register_file.sv ====
module register_file (
    input  logic           system_clk,
    input  logic           we,
    input  logic [1:0]     wr_addr,
    input  cpu_pkg::data_t wr_data,
    input  logic [1:0]     rd_l_addr,  // Port L feeds the A bus
    output cpu_pkg::data_t rd_l_data,
    input  logic [1:0]     rd_r_addr,  // Port R feeds the B bus
    output cpu_pkg::data_t rd_r_data
);

    cpu_pkg::data_t regs [4];  // rega to regd

    always_ff @(posedge system_clk) begin
        if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads see the old value during a write cycle
    assign rd_l_data = regs[rd_l_addr];
    assign rd_r_data = regs[rd_r_addr];

endmodule

// ==== verilog/data_ram.sv ====
module data_ram #(
    parameter int ram_depth = 256
) (
    input  logic           system_clk,
    input  logic           mar_lo_we,
    input  logic           mar_hi_we,
    input  logic           ram_we,
    input  cpu_pkg::data_t wr_data,   // ALU result
    output cpu_pkg::data_t mar_lo,
    output cpu_pkg::data_t mar_hi,    // General register only, no upper address
    output cpu_pkg::data_t ram_data
);

    localparam int aw = $clog2(ram_depth);  // Smaller RAMs use low MAR bits

    cpu_pkg::data_t mem [ram_depth];

    always_ff @(posedge system_clk) begin
        if (mar_lo_we) begin
            mar_lo <= wr_data;
        end
        if (mar_hi_we) begin
            mar_hi <= wr_data;
        end
        if (ram_we) begin
            mem[mar_lo[aw-1:0]] <= wr_data;  // Address from before this edge
        end
    end

    assign ram_data = mem[mar_lo[aw-1:0]];  // Async read onto the B bus

endmodule

// ==== verilog/byte_port.sv ====
module byte_port (
    input  logic           system_clk,
    input  logic           rst,
    input  cpu_pkg::data_t rx_data,
    input  logic           rx_valid,
    output logic           rx_ready,
    output cpu_pkg::data_t tx_data,
    output logic           tx_valid,
    input  logic           tx_ready,
    input  logic           rx_take,   // CPU consumed the received byte
    input  logic           tx_load,   // CPU writes a byte to send
    input  cpu_pkg::data_t tx_byte,
    output cpu_pkg::data_t rx_byte,
    output logic           di,        // Data in available
    output logic           do_rdy     // Room for data out
);

    logic           rx_full;
    cpu_pkg::data_t rx_hold;

    assign rx_ready = !rx_full;  // One byte deep
    assign rx_byte  = rx_hold;
    assign di       = rx_full;

    // Receive side, fill and take never overlap as take needs a full holder
    always_ff @(posedge system_clk) begin
        if (rst) begin
            rx_full <= 1'b0;
        end else if (rx_valid && rx_ready) begin
            rx_full <= 1'b1;
        end else if (rx_take) begin
            rx_full <= 1'b0;
        end
    end

    always_ff @(posedge system_clk) begin
        if (rx_valid && rx_ready) begin
            rx_hold <= rx_data;
        end
    end

    assign do_rdy = !tx_valid;

    // Transmit side, holds the byte until tx_ready is seen
    always_ff @(posedge system_clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else if (tx_load) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;  // Accepted, or idle already
        end
    end

    always_ff @(posedge system_clk) begin
        if (tx_load) begin
            tx_data <= tx_byte;
        end
    end

endmodule

// ==== verilog/cpu.sv ====
module cpu #(
    parameter int rom_depth = 256,
    parameter int ram_depth = 256
) (
    input  logic            system_clk,
    input  logic            rst,
    input  logic            prog_we,
    input  cpu_pkg::pc_t    prog_addr,
    input  cpu_pkg::instr_t prog_data,
    input  cpu_pkg::data_t  rx_data,
    input  logic            rx_valid,
    output logic            rx_ready,
    output cpu_pkg::data_t  tx_data,
    output logic            tx_valid,
    input  logic            tx_ready,
    output logic            halted,
    output cpu_pkg::flags_t flags
);

    cpu_pkg::pc_t    pc;
    cpu_pkg::instr_t instr;
    cpu_pkg::data_t  a_bus;
    cpu_pkg::data_t  b_bus;
    cpu_pkg::data_t  result;      // ALU result bus, written to every target
    cpu_pkg::flags_t alu_flags;
    cpu_pkg::data_t  rd_l_data;
    cpu_pkg::data_t  rd_r_data;
    cpu_pkg::data_t  mar_lo;
    cpu_pkg::data_t  mar_hi;
    cpu_pkg::data_t  ram_data;
    cpu_pkg::data_t  rx_byte;
    logic            di;
    logic            do_rdy;
    logic            reg_we;
    logic            mar_lo_we;
    logic            mar_hi_we;
    logic            ram_we;
    logic            tx_load;
    logic            rx_take;

    program_rom #(.depth(rom_depth)) rom_i (
        .system_clk, .prog_we, .prog_addr, .prog_data, .pc, .instr
    );

    sequencer seq_i (
        .system_clk, .rst, .instr, .result, .alu_flags, .di, .do_rdy,
        .pc, .flags, .reg_we, .mar_lo_we, .mar_hi_we, .ram_we,
        .tx_load, .rx_take, .halted
    );

    // A bus source select
    always_comb begin
        case (instr.adev)
            cpu_pkg::adev_marlo: a_bus = mar_lo;
            cpu_pkg::adev_marhi: a_bus = mar_hi;
            cpu_pkg::adev_rx:    a_bus = rx_byte;
            cpu_pkg::adev_zero:  a_bus = '0;
            default:             a_bus = rd_l_data;  // rega to regd
        endcase
    end

    // B bus source select
    always_comb begin
        case (instr.bdev)
            cpu_pkg::bdev_marlo: b_bus = mar_lo;
            cpu_pkg::bdev_marhi: b_bus = mar_hi;
            cpu_pkg::bdev_ram:   b_bus = ram_data;
            cpu_pkg::bdev_immed: b_bus = instr.immed8;
            default:             b_bus = rd_r_data;
        endcase
    end

    alu alu_i (
        .a(a_bus), .b(b_bus), .op(instr.alu_op),
        .carry_in(flags.c),  // From the status register
        .result, .flags(alu_flags)
    );

    // Register indexes are the low bits of the device codes
    register_file regs_i (
        .system_clk, .we(reg_we), .wr_addr(instr.targ[1:0]), .wr_data(result),
        .rd_l_addr(instr.adev[1:0]), .rd_l_data,
        .rd_r_addr(instr.bdev[1:0]), .rd_r_data
    );

    data_ram #(.ram_depth(ram_depth)) ram_i (
        .system_clk, .mar_lo_we, .mar_hi_we, .ram_we, .wr_data(result),
        .mar_lo, .mar_hi, .ram_data
    );

    byte_port port_i (
        .system_clk, .rst, .rx_data, .rx_valid, .rx_ready,
        .tx_data, .tx_valid, .tx_ready,
        .rx_take, .tx_load, .tx_byte(result), .rx_byte, .di, .do_rdy
    );

endmodule

// ==== verif/clock_gen.sv ====
module clock_gen #(
    parameter int period = 40  // Full clock period in time units
) (
    output logic system_clk
);

    initial begin
        system_clk = 1'b0;
        forever begin
            #(period / 2) system_clk = ~system_clk;  // Rising edges at odd half periods
        end
    end

endmodule

// ==== verif/cpu_tb.sv ====
module cpu_tb;

    localparam int clk_period  = 40;
    localparam int rst_cycles  = 16;
    localparam int test_cycles = 2000;  // Watchdog budget for each test
    localparam int tail_cycles = 40;    // Drain the tx holder after halt

    logic            system_clk;
    logic            rst;
    logic            prog_we;
    cpu_pkg::pc_t    prog_addr;
    cpu_pkg::instr_t prog_data;
    cpu_pkg::data_t  rx_data;
    logic            rx_valid;
    logic            rx_ready;
    cpu_pkg::data_t  tx_data;
    logic            tx_valid;
    logic            tx_ready;
    logic            halted;
    cpu_pkg::flags_t flags;

    byte             kind_q [$];   // Record letters in file order
    logic [31:0]     val_a_q [$];
    logic [31:0]     val_b_q [$];
    int              num_tests;
    bit              loaded;       // Stimulus parsed, watchdog may start

    cpu_pkg::pc_t    prog_addr_q [$];
    logic [25:0]     prog_word_q [$];
    cpu_pkg::data_t  rx_q [$];     // Bytes to feed in this test
    cpu_pkg::data_t  exp_q [$];    // Bytes expected on tx
    cpu_pkg::flags_t exp_flags;
    int              rx_idx;
    int              tx_idx;

    clock_gen #(.period(clk_period)) clk_i (.system_clk);

    cpu #(.rom_depth(256), .ram_depth(256)) dut_i (
        .system_clk, .rst, .prog_we, .prog_addr, .prog_data,
        .rx_data, .rx_valid, .rx_ready, .tx_data, .tx_valid, .tx_ready,
        .halted, .flags
    );

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input cpu_pkg::data_t act,
                              input cpu_pkg::data_t exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_flags(input string name, input cpu_pkg::flags_t act,
                               input cpu_pkg::flags_t exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic read_stimulus();
        int          fd;
        int          c;
        int          n;
        int          need;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("verif/cpu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/cpu_stimulus.txt");
            fail_run();
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);  // Skip comment line
                end
            end else if (c == "P" || c == "R" || c == "E" || c == "F" || c == "T") begin
                a    = '0;
                b    = '0;
                n    = 0;
                need = (c == "P") ? 2 : ((c == "T") ? 0 : 1);
                if (need == 2) begin
                    n = $fscanf(fd, "%h %h", a, b);
                end else if (need == 1) begin
                    n = $fscanf(fd, "%h", a);
                end
                if (n != need) begin
                    $display("malformed record in the stimulus file");
                    fail_run();
                end
                kind_q.push_back(byte'(c));
                val_a_q.push_back(a);
                val_b_q.push_back(b);
                if (c == "T") begin
                    num_tests++;
                end
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (num_tests == 0) begin
            $display("the stimulus file holds no tests");
            fail_run();
        end
    endtask

    // Gather the records of one test, up to and past its T
    task automatic collect_test(inout int rec);
        logic [31:0] v;
        logic [31:0] w;
        prog_addr_q.delete();
        prog_word_q.delete();
        rx_q.delete();
        exp_q.delete();
        exp_flags = '0;
        while (kind_q[rec] != "T") begin
            v = val_a_q[rec];
            w = val_b_q[rec];
            case (kind_q[rec])
                "P": begin
                    prog_addr_q.push_back(v[7:0]);
                    prog_word_q.push_back(w[25:0]);
                end
                "R":     rx_q.push_back(v[7:0]);
                "E":     exp_q.push_back(v[7:0]);
                default: exp_flags = v[7:0];  // F record
            endcase
            rec++;
        end
        rec++;
    endtask

    task automatic check_reset_state();
        check_bit("tx_valid", tx_valid, 1'b0);
        check_bit("halted", halted, 1'b0);
        check_flags("flags", flags, '0);
        check_bit("rx_ready", rx_ready, 1'b1);
    endtask

    // Program words go in while rst is high
    task automatic reset_and_load();
        if (prog_addr_q.size() > rst_cycles) begin
            $display("more program words in one test than reset cycles");
            fail_run();
        end
        rst      = 1'b1;
        rx_valid = 1'b0;
        tx_ready = 1'b0;
        for (int i = 0; i < rst_cycles; i++) begin
            if (i > 0) begin
                check_reset_state();  // At least one reset edge seen
            end
            prog_we = (i < prog_addr_q.size());
            if (prog_we) begin
                prog_addr = prog_addr_q[i];
                prog_data = prog_word_q[i];
            end
            @(negedge system_clk);
        end
        check_reset_state();
        rst     = 1'b0;
        prog_we = 1'b0;
        rx_idx  = 0;
        tx_idx  = 0;
    endtask

    // Drive at the falling edge, then count the transfers of the next rising edge
    task automatic step_cycle();
        if (rx_idx < rx_q.size() && $urandom_range(0, 3) != 0) begin
            rx_valid = 1'b1;
            rx_data  = rx_q[rx_idx];
        end else begin
            rx_valid = 1'b0;  // Random gap
        end
        if (rx_valid && rx_ready) begin
            rx_idx++;
        end
        tx_ready = ($urandom_range(0, 2) != 0);
        if (tx_valid && tx_ready) begin
            if (tx_idx >= exp_q.size()) begin
                $display("transmitted more bytes than expected");
                fail_run();
            end else begin
                check_data("tx_data", tx_data, exp_q[tx_idx]);
                tx_idx++;
            end
        end
        @(negedge system_clk);
    endtask

    task automatic run_program();
        while (!halted) begin
            step_cycle();
        end
        repeat (tail_cycles) begin
            step_cycle();
            check_bit("halted", halted, 1'b1);  // Held until the next reset
        end
        if (tx_idx != exp_q.size()) begin
            $display("transmitted fewer bytes than expected");
            fail_run();
        end
        if (rx_idx != rx_q.size()) begin
            $display("not every receive byte was taken by the CPU");
            fail_run();
        end
        check_flags("flags", flags, exp_flags);
    endtask

    initial begin
        int          rec;
        int unsigned seed_ret;
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        rx_data   = '0;
        rx_valid  = 1'b0;
        tx_ready  = 1'b0;
        num_tests = 0;
        loaded    = 1'b0;
        seed_ret  = $urandom(32'h74dc_802c);  // Seed once for the whole run
        read_stimulus();
        loaded = 1'b1;
        rec    = 0;
        wait (system_clk === 1'b0);  // Clock leaves x at time zero
        for (int t = 0; t < num_tests; t++) begin
            collect_test(rec);
            reset_and_load();
            run_program();
        end
        $display("PASS: all tests");
        $finish;
    end

    // Watchdog sized from the number of tests
    initial begin
        wait (loaded);
        #(num_tests * test_cycles * clk_period);
        $display("timeout, the CPU did not halt in time");
        fail_run();
    end

endmodule

// ==== verif/cpu_stimulus.txt ====
# P addr word (26 bit hex instr), R rx byte, E expected tx byte, F final flags czonGLEN
# T closes a test, a line starting with # is a comment
# Arithmetic, logic ops and flags
P 00 0043f3c
P 01 0047fc8
P 02 049c100
P 03 04dc710
P 04 051c800
P 05 019c70f
P 06 01dc100
P 07 061c7ff
P 08 0027f00
E 04
E 4d
E 8c
E 0c
E fc
E c3
F 15
T
# Counted loop, skipped instructions, tx after halt never seen
P 00 0043f00
P 01 001c700
P 02 0300700
P 03 0528703
P 04 3863f01
P 05 145ffee
P 06 1843f55
P 07 081c700
P 08 0027f00
P 09 005ff99
E 00
E 01
E 02
E 03
F 42
T
# RAM through MAR low, read back in another order
P 00 0053f10
P 01 005bfa1
P 02 0053f11
P 03 005bfb2
P 04 005fe00
P 05 0053f10
P 06 005fe00
P 07 0027f00
E b2
E a1
F 00
T
# Echo with di polling, stalls and a do guarded halt
P 00 0047f06
P 01 2863f03
P 02 0063f01
P 03 001f700
P 04 0744f00
P 05 1063f01
P 06 3027f00
P 07 0063f06
R 5a
R a5
R 00
R ff
R 13
R 7e
E 5a
E a5
E 00
E ff
E 13
E 7e
F 49
T

// ==== cpu.f ====
verilog/cpu_pkg.sv
verilog/program_rom.sv
verilog/sequencer.sv
verilog/alu.sv
verilog/register_file.sv
verilog/data_ram.sv
verilog/byte_port.sv
verilog/cpu.sv
verif/clock_gen.sv
verif/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - verilog/cpu_pkg.sv
  - verilog/program_rom.sv
  - verilog/sequencer.sv
  - verilog/alu.sv
  - verilog/register_file.sv
  - verilog/data_ram.sv
  - verilog/byte_port.sv
  - verilog/cpu.sv
  - target: test
    files:
      - verif/clock_gen.sv
      - verif/cpu_tb.sv
